//--- rv_backend.f
hdl/rv_isa_pkg.sv
hdl/pipe_pkg.sv
hdl/alu.sv
hdl/ex_control.sv
hdl/ex_stage.sv
hdl/mem_stage.sv
hdl/rv_backend.sv
tests/tb_rv_backend.sv

//--- tests/tb_rv_backend.sv
`timescale 1ns/1ps

module tb_rv_backend import rv_isa_pkg::*, pipe_pkg::*; ();

    localparam int DMEM_WORDS = 256;
    localparam logic [2:0] F3_WORD = 3'b010; // lw / sw

    logic        clk;
    logic        rst_n;
    ex_in_t      ex_in;
    logic        flush;
    logic [31:0] redirect_pc;
    logic        br_update;
    logic [31:0] tohost;
    wb_bundle_t  wb;

    // Decode-side register file and reference data memory
    logic [31:0] regs [32];
    logic [31:0] dmem_model [DMEM_WORDS];
    wb_bundle_t  wb_exp [$]; // Entries for the two instructions ahead of EX
    logic        exp_br_suc;
    logic [31:0] exp_tohost;
    logic [31:0] pc;
    int unsigned seed;

    rv_backend #(
        .DMEM_WORDS (DMEM_WORDS)
    ) DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .ex_in       (ex_in),
        .flush       (flush),
        .redirect_pc (redirect_pc),
        .br_update   (br_update),
        .tohost      (tohost),
        .wb          (wb)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_wb(input wb_bundle_t exp);
        if (wb.inst !== exp.inst || wb.rd !== exp.rd || wb.we !== exp.we ||
                (exp.we && wb.wdata !== exp.wdata)) begin
            stop_run($sformatf(
                "mismatch at %0t: wb inst %h rd %0d we %b wdata %h, expected %h %0d %b %h",
                $time, wb.inst, wb.rd, wb.we, wb.wdata, exp.inst, exp.rd, exp.we, exp.wdata));
        end
    endtask

    task automatic check_redirect(input logic exp_flush, input logic [31:0] exp_pc);
        if (flush !== exp_flush || (exp_flush && redirect_pc !== exp_pc)) begin
            stop_run($sformatf(
                "mismatch at %0t: flush %b redirect_pc %h, expected flush %b redirect_pc %h",
                $time, flush, redirect_pc, exp_flush, exp_pc));
        end
    endtask

    task automatic check_br_update(input logic exp);
        if (br_update !== exp) begin
            stop_run($sformatf("mismatch at %0t: br_update %b, expected %b",
                               $time, br_update, exp));
        end
    endtask

    task automatic check_tohost(input logic [31:0] exp);
        if (tohost !== exp) begin
            stop_run($sformatf("mismatch at %0t: tohost %h, expected %h", $time, tohost, exp));
        end
    endtask

    function automatic wb_bundle_t idle_wb();
        wb_bundle_t w;
        w      = '0;
        w.inst = NOP;
        return w;
    endfunction

    function automatic logic [31:0] enc(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
            input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    // ISA reference for one instruction on the architectural state
    task automatic execute(input ex_in_t x, output wb_bundle_t w, output logic fl,
            output logic [31:0] rpc, output logic suc);
        logic [31:0] iw;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] bb;
        logic [31:0] res;
        logic        cond;
        iw   = x.inst;
        a    = regs[iw[19:15]];
        b    = regs[iw[24:20]];
        res  = a + x.imm; // Address for loads and stores
        fl   = 1'b0;
        rpc  = x.pc + 32'd4;
        suc  = 1'b0;
        cond = 1'b0;
        case (iw[6:0])
            OPC_OP, OPC_OP_IMM: begin
                bb = (iw[6:0] == OPC_OP) ? b : x.imm;
                case (iw[14:12])
                    F3_ADD:  res = (iw[6:0] == OPC_OP && iw[30]) ? a - bb : a + bb;
                    F3_SLL:  res = a << bb[4:0];
                    F3_SLT:  res = ($signed(a) < $signed(bb)) ? 32'd1 : 32'd0;
                    F3_SLTU: res = (a < bb) ? 32'd1 : 32'd0;
                    F3_XOR:  res = a ^ bb;
                    F3_SR: begin
                        if (iw[30])
                            res = $signed(a) >>> bb[4:0];
                        else
                            res = a >> bb[4:0];
                    end
                    F3_OR:   res = a | bb;
                    default: res = a & bb;
                endcase
            end
            OPC_LUI:   res = x.imm;
            OPC_AUIPC: res = x.pc + x.imm;
            OPC_JAL, OPC_JALR: begin
                res = x.pc + 32'd4; // Link
                fl  = 1'b1;
                rpc = (iw[6:0] == OPC_JAL) ? x.pc + x.imm : (a + x.imm) & ~32'd1;
            end
            OPC_BRANCH: begin
                case (iw[14:12])
                    F3_BEQ:  cond = a == b;
                    F3_BNE:  cond = a != b;
                    F3_BLT:  cond = $signed(a) < $signed(b);
                    F3_BGE:  cond = $signed(a) >= $signed(b);
                    F3_BLTU: cond = a < b;
                    default: cond = a >= b;
                endcase
                fl  = cond != x.br_taken;
                suc = !fl;
                if (cond)
                    rpc = x.pc + x.imm;
            end
            OPC_LOAD:  res = dmem_model[(res >> 2) % DMEM_WORDS];
            OPC_STORE: dmem_model[(res >> 2) % DMEM_WORDS] = b;
            OPC_SYSTEM: begin
                if (iw[31:20] == CSR_TOHOST && iw[14:12] == F3_CSRRW)
                    exp_tohost = a;
                else if (iw[31:20] == CSR_TOHOST && iw[14:12] == F3_CSRRWI)
                    exp_tohost = {27'd0, iw[19:15]}; // uimm
            end
            default: ;
        endcase
        w.inst  = iw;
        w.rd    = iw[11:7];
        w.wdata = res;
        w.we    = iw[6:0] != OPC_STORE && iw[6:0] != OPC_BRANCH && iw[11:7] != 5'd0;
        if (w.we)
            regs[iw[11:7]] = res;
    endtask

    // One cycle: check what left the pipe, then present the next instruction
    task automatic issue(input logic [31:0] iw, input logic [31:0] imm, input logic pred,
            input logic stale);
        ex_in_t      x;
        wb_bundle_t  w;
        logic        fl;
        logic [31:0] rpc;
        logic        suc;
        @(negedge clk);
        check_wb(wb_exp.pop_front());
        check_br_update(exp_br_suc);
        check_tohost(exp_tohost);
        x.pc       = pc;
        x.inst     = iw;
        x.rd1      = stale ? 32'd0 : regs[iw[19:15]]; // Stale operands need forwarding
        x.rd2      = stale ? 32'd0 : regs[iw[24:20]];
        x.imm      = imm;
        x.br_taken = pred;
        ex_in      = x;
        execute(x, w, fl, rpc, suc);
        wb_exp.push_back(w);
        exp_br_suc = suc;
        pc = fl ? rpc : pc + 32'd4;
        #5;
        check_redirect(fl, rpc);
    endtask

    task automatic issue_i(input logic [6:0] op, input logic [2:0] f3, input logic [4:0] rd,
            input logic [4:0] rs1, input logic [11:0] imm, input logic stale);
        issue(enc(imm[11:5], imm[4:0], rs1, f3, rd, op), {{20{imm[11]}}, imm}, 1'b0, stale);
    endtask

    task automatic nop();
        issue(NOP, 32'd0, 1'b0, 1'b0);
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (wb_exp[0].we || wb_exp[1].we) begin
            if (n == 8) begin
                stop_run("timeout: register writes still pending after 8 idle cycles");
            end else begin
                nop();
                n++;
            end
        end
    endtask

    // Whatever sits in EX stays there until release
    task automatic apply_reset();
        @(negedge clk);
        rst_n = 1'b0;
        repeat (16) @(negedge clk);
        rst_n      = 1'b1;
        ex_in      = '0;
        ex_in.inst = NOP;
        wb_exp.delete();
        wb_exp.push_back(idle_wb());
        wb_exp.push_back(idle_wb());
        exp_br_suc = 1'b0;
        exp_tohost = 32'd0;
    endtask

    task automatic test_alu();
        logic [11:0] imm;
        logic [31:0] u;
        regs[1] = $urandom | 32'h8000_0000; // Negative, for sra
        regs[2] = $urandom;
        for (int f = 0; f < 8; f++) begin
            issue(enc(7'h00, 5'd2, 5'd1, f[2:0], 5'd3, OPC_OP), 32'd0, 1'b0, 1'b0);
            nop();
            imm = 12'($urandom);
            if (f == 1 || f == 5)
                imm[11:5] = 7'h00;
            issue_i(OPC_OP_IMM, f[2:0], 5'd4, 5'd1, imm, 1'b0);
            nop();
        end
        issue(enc(7'h20, 5'd2, 5'd1, F3_ADD, 5'd3, OPC_OP), 32'd0, 1'b0, 1'b0); // sub
        nop();
        issue(enc(7'h20, 5'd2, 5'd1, F3_SR, 5'd3, OPC_OP), 32'd0, 1'b0, 1'b0); // sra
        nop();
        issue_i(OPC_OP_IMM, F3_SR, 5'd4, 5'd1, {7'h20, 5'($urandom)}, 1'b0); // srai
        nop();
        u = $urandom;
        issue({u[31:12], 5'd5, OPC_LUI}, {u[31:12], 12'd0}, 1'b0, 1'b0);
        nop();
        u = $urandom;
        issue({u[31:12], 5'd5, OPC_AUIPC}, {u[31:12], 12'd0}, 1'b0, 1'b0);
        nop();
    endtask

    task automatic test_forwarding();
        issue_i(OPC_OP_IMM, F3_ADD, 5'd5, 5'd0, 12'($urandom), 1'b0);
        issue_i(OPC_OP_IMM, F3_ADD, 5'd6, 5'd0, 12'($urandom), 1'b0);
        issue(enc(7'h00, 5'd6, 5'd5, F3_ADD, 5'd7, OPC_OP), 32'd0, 1'b0, 1'b1);
        issue(enc(7'h20, 5'd6, 5'd7, F3_ADD, 5'd8, OPC_OP), 32'd0, 1'b0, 1'b1);
        // Same rd twice, the younger one in MEM must win
        issue_i(OPC_OP_IMM, F3_ADD, 5'd9, 5'd0, 12'($urandom), 1'b0);
        issue_i(OPC_OP_IMM, F3_ADD, 5'd9, 5'd0, 12'($urandom), 1'b0);
        issue(enc(7'h00, 5'd9, 5'd9, F3_ADD, 5'd10, OPC_OP), 32'd0, 1'b0, 1'b1);
        issue_i(OPC_OP_IMM, F3_ADD, 5'd0, 5'd0, 12'h07b, 1'b0);
        issue_i(OPC_OP_IMM, F3_ADD, 5'd10, 5'd0, 12'h000, 1'b1); // x0 not forwarded
        issue_i(OPC_OP_IMM, F3_ADD, 5'd18, 5'd0, 12'($urandom), 1'b0);
        nop();
        issue_i(OPC_OP_IMM, F3_XOR, 5'd19, 5'd18, 12'($urandom), 1'b1);
        drain();
    endtask

    task automatic test_branches();
        logic [2:0]  conds [6];
        logic [31:0] imm;
        conds = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
        for (int i = 0; i < 6; i++) begin
            for (int k = 0; k < 4; k++) begin
                regs[11] = $urandom;
                regs[12] = k[0] ? regs[11] : $urandom;
                imm = 32'(($urandom % 256) * 4) - 32'd512;
                issue(enc({imm[12], imm[10:5]}, 5'd12, 5'd11, conds[i], {imm[4:1], imm[11]},
                          OPC_BRANCH), imm, k[1], 1'b0);
                nop(); // Wrong path slot
            end
        end
        imm = 32'(($urandom % 1024) * 4) - 32'd2048;
        issue({imm[20], imm[10:1], imm[11], imm[19:12], 5'd13, OPC_JAL}, imm, 1'b0, 1'b0);
        nop();
        issue_i(OPC_JALR, 3'b000, 5'd14, 5'd11, 12'($urandom), 1'b0);
        nop();
        drain();
    endtask

    task automatic test_memory();
        logic [11:0] addrs [4];
        for (int k = 0; k < 4; k++) begin
            addrs[k] = {2'b00, 8'($urandom), 2'b00};
            regs[15] = $urandom;
            issue(enc(addrs[k][11:5], 5'd15, 5'd0, F3_WORD, addrs[k][4:0], OPC_STORE),
                  {20'd0, addrs[k]}, 1'b0, 1'b0);
        end
        for (int k = 0; k < 4; k++) begin
            issue_i(OPC_LOAD, F3_WORD, 5'(16 + k), 5'd0, addrs[k], 1'b0);
        end
        drain();
    endtask

    task automatic test_tohost();
        issue_i(OPC_OP_IMM, F3_ADD, 5'd17, 5'd0, 12'($urandom), 1'b0);
        issue_i(OPC_SYSTEM, F3_CSRRW, 5'd0, 5'd17, CSR_TOHOST, 1'b1); // From MEM
        nop();
        issue_i(OPC_SYSTEM, F3_CSRRWI, 5'd0, 5'(($urandom % 31) + 1), CSR_TOHOST, 1'b0);
        issue_i(OPC_OP_IMM, F3_ADD, 5'd17, 5'd0, 12'($urandom), 1'b0);
        nop();
        issue_i(OPC_SYSTEM, F3_CSRRW, 5'd0, 5'd17, CSR_TOHOST, 1'b1); // From WB
        nop();
        nop();
    endtask

    task automatic test_reset();
        regs[11] = 32'h5;
        regs[12] = 32'h5;
        issue_i(OPC_SYSTEM, F3_CSRRWI, 5'd0, 5'd9, CSR_TOHOST, 1'b0);
        // Taken beq predicted not taken
        issue(enc(7'h00, 5'd12, 5'd11, F3_BEQ, 5'd8, OPC_BRANCH), 32'd8, 1'b0, 1'b0);
        // Held in EX through reset, the stage registers must not pass it on
        issue_i(OPC_OP_IMM, F3_ADD, 5'd20, 5'd0, 12'h123, 1'b0);
        apply_reset();
        #5;
        check_wb(idle_wb());
        check_tohost(32'd0);
        check_redirect(1'b0, 32'd0);
        nop();
        nop();
        nop();
    endtask

    initial begin
        seed       = $urandom(42);
        rst_n      = 1'b0;
        ex_in      = '0;
        ex_in.inst = NOP;
        pc         = 32'h0000_0100;
        for (int r = 0; r < 32; r++) begin
            regs[r] = 32'd0;
        end
        apply_reset();
        test_alu();
        test_forwarding();
        test_branches();
        test_memory();
        test_tohost();
        test_reset();
        drain();
        $display("all tests passed");
        $finish;
    end

endmodule

//--- hdl/rv_backend.sv
`timescale 1ns/1ps

module rv_backend import pipe_pkg::*; #(
    parameter int DMEM_WORDS = 256
) (
    input  logic        clk,
    input  logic        rst_n,
    input  ex_in_t      ex_in,
    output logic        flush,
    output logic [31:0] redirect_pc,
    output logic        br_update,
    output logic [31:0] tohost,
    output wb_bundle_t  wb
);

    mem_bundle_t mem_bundle;

    ex_stage u_ex_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .ex_in       (ex_in),
        .wb          (wb), // WB forwarding path
        .mem_bundle  (mem_bundle),
        .flush       (flush),
        .redirect_pc (redirect_pc),
        .tohost      (tohost)
    );

    mem_stage #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_mem_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem_bundle (mem_bundle),
        .wb         (wb)
    );

    assign br_update = mem_bundle.br_suc;

endmodule

//--- hdl/mem_stage.sv
`timescale 1ns/1ps

module mem_stage import rv_isa_pkg::*, pipe_pkg::*; #(
    parameter int DMEM_WORDS = 256
) (
    input  logic        clk,
    input  logic        rst_n,
    input  mem_bundle_t mem_bundle,
    output wb_bundle_t  wb
);

    localparam int AW = $clog2(DMEM_WORDS);

    logic [31:0]   dmem [DMEM_WORDS];
    logic [AW-1:0] addr;
    logic [31:0]   load_data;
    logic [31:0]   wdata;
    logic [4:0]    rd;
    logic          we;
    opcode_e       opcode;

    assign opcode = mem_bundle.inst.s.opcode;
    assign addr   = mem_bundle.alu[AW+1:2]; // Word index, wraps

    always_ff @(posedge clk) begin
        if (opcode == OPC_STORE) begin
            dmem[addr] <= mem_bundle.rd2;
        end
    end

    assign load_data = dmem[addr];

    always_comb begin
        case (opcode)
            OPC_LOAD:          wdata = load_data;
            OPC_JAL, OPC_JALR: wdata = mem_bundle.pc + 32'd4; // Link address
            default:           wdata = mem_bundle.alu;
        endcase
    end

    assign rd = mem_bundle.inst.i.rd;
    assign we = opcode != OPC_STORE && opcode != OPC_BRANCH && rd != 5'd0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb.inst <= NOP;
            wb.rd   <= '0;
            wb.we   <= 1'b0;
        end else begin
            wb.inst <= mem_bundle.inst;
            wb.rd   <= rd;
            wb.we   <= we;
        end
    end

    always_ff @(posedge clk) begin
        wb.wdata <= wdata;
    end

endmodule

//--- hdl/ex_stage.sv
`timescale 1ns/1ps

module ex_stage import rv_isa_pkg::*, pipe_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  ex_in_t      ex_in,
    input  wb_bundle_t  wb,
    output mem_bundle_t mem_bundle,
    output logic        flush,
    output logic [31:0] redirect_pc,
    output logic [31:0] tohost
);

    fwd_sel_e    fwda;
    fwd_sel_e    fwdb;
    a_sel_e      asel;
    b_sel_e      bsel;
    alu_op_e     alu_op;
    logic        csr_en;
    logic        csr_imm;
    logic        br_taken_actual;
    logic        br_suc;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] alu_res;
    logic [31:0] pc_plus4;

    always_comb begin
        case (fwda)
            FWD_MEM: rs1_val = mem_bundle.alu;
            FWD_WB:  rs1_val = wb.wdata;
            default: rs1_val = ex_in.rd1;
        endcase
        case (fwdb)
            FWD_MEM: rs2_val = mem_bundle.alu;
            FWD_WB:  rs2_val = wb.wdata;
            default: rs2_val = ex_in.rd2;
        endcase
    end

    assign a = (asel == A_PC) ? ex_in.pc : rs1_val;
    assign b = (bsel == B_IMM) ? ex_in.imm : rs2_val;

    alu u_alu (
        .a   (a),
        .b   (b),
        .op  (alu_op),
        .res (alu_res)
    );

    ex_control u_ex_control (
        .inst            (ex_in.inst),
        .mem_inst        (mem_bundle.inst),
        .wb_inst         (wb.inst),
        .rs1_val         (rs1_val),
        .rs2_val         (rs2_val),
        .br_taken        (ex_in.br_taken),
        .fwda            (fwda),
        .fwdb            (fwdb),
        .asel            (asel),
        .bsel            (bsel),
        .alu_op          (alu_op),
        .csr_en          (csr_en),
        .csr_imm         (csr_imm),
        .flush           (flush),
        .br_taken_actual (br_taken_actual),
        .br_suc          (br_suc)
    );

    assign pc_plus4 = ex_in.pc + 32'd4;
    // Bit 0 cleared for JALR, already zero otherwise
    assign redirect_pc = br_taken_actual ? {alu_res[31:1], 1'b0} : pc_plus4;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tohost <= '0;
        end else if (csr_en) begin
            tohost <= csr_imm ? {27'b0, ex_in.inst.i.rs1} : rs1_val; // uimm sits in rs1 field
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_bundle.inst   <= NOP;
            mem_bundle.br_suc <= 1'b0;
        end else begin
            mem_bundle.inst   <= ex_in.inst;
            mem_bundle.br_suc <= br_suc;
        end
    end

    always_ff @(posedge clk) begin
        mem_bundle.pc  <= ex_in.pc;
        mem_bundle.alu <= alu_res;
        mem_bundle.rd2 <= rs2_val;
    end

endmodule

//--- hdl/ex_control.sv
`timescale 1ns/1ps

module ex_control import rv_isa_pkg::*, pipe_pkg::*; (
    input  rv_inst_t    inst,
    input  rv_inst_t    mem_inst,
    input  rv_inst_t    wb_inst,
    input  logic [31:0] rs1_val,
    input  logic [31:0] rs2_val,
    input  logic        br_taken,
    output fwd_sel_e    fwda,
    output fwd_sel_e    fwdb,
    output a_sel_e      asel,
    output b_sel_e      bsel,
    output alu_op_e     alu_op,
    output logic        csr_en,
    output logic        csr_imm,
    output logic        flush,
    output logic        br_taken_actual,
    output logic        br_suc
);

    logic is_branch;
    logic is_jump;
    logic cond;

    function automatic logic writes_rd(input rv_inst_t i);
        return i.u.opcode != OPC_STORE && i.u.opcode != OPC_BRANCH;
    endfunction

    // MEM wins over WB, x0 never forwarded
    function automatic fwd_sel_e pick_fwd(input logic [4:0] rs, input rv_inst_t m,
            input rv_inst_t w);
        if (rs != 5'd0 && writes_rd(m) && m.r.rd == rs)
            return FWD_MEM;
        if (rs != 5'd0 && writes_rd(w) && w.r.rd == rs)
            return FWD_WB;
        return FWD_NONE;
    endfunction

    assign fwda = pick_fwd(inst.r.rs1, mem_inst, wb_inst);
    assign fwdb = pick_fwd(inst.r.rs2, mem_inst, wb_inst);

    always_comb begin
        asel   = A_REG;
        bsel   = B_REG;
        alu_op = ALU_ADD;
        case (inst.u.opcode)
            OPC_OP, OPC_OP_IMM: begin
                bsel = (inst.u.opcode == OPC_OP_IMM) ? B_IMM : B_REG;
                case (inst.r.funct3)
                    F3_ADD:  alu_op = (inst.u.opcode == OPC_OP && inst.r.funct7[5]) ?
                                      ALU_SUB : ALU_ADD;
                    F3_SLL:  alu_op = ALU_SLL;
                    F3_SLT:  alu_op = ALU_SLT;
                    F3_SLTU: alu_op = ALU_SLTU;
                    F3_XOR:  alu_op = ALU_XOR;
                    F3_SR:   alu_op = inst.r.funct7[5] ? ALU_SRA : ALU_SRL;
                    F3_OR:   alu_op = ALU_OR;
                    F3_AND:  alu_op = ALU_AND;
                    default: alu_op = ALU_ADD;
                endcase
            end
            OPC_LUI: begin
                bsel   = B_IMM;
                alu_op = ALU_COPY_B;
            end
            OPC_AUIPC, OPC_JAL, OPC_BRANCH: begin // pc + imm
                asel = A_PC;
                bsel = B_IMM;
            end
            OPC_JALR, OPC_LOAD, OPC_STORE: bsel = B_IMM;
            default: ;
        endcase
    end

    always_comb begin
        case (inst.r.funct3)
            F3_BEQ:  cond = rs1_val == rs2_val;
            F3_BNE:  cond = rs1_val != rs2_val;
            F3_BLT:  cond = $signed(rs1_val) < $signed(rs2_val);
            F3_BGE:  cond = $signed(rs1_val) >= $signed(rs2_val);
            F3_BLTU: cond = rs1_val < rs2_val;
            F3_BGEU: cond = rs1_val >= rs2_val;
            default: cond = 1'b0;
        endcase
    end

    assign is_branch = inst.u.opcode == OPC_BRANCH;
    assign is_jump   = inst.u.opcode == OPC_JAL || inst.u.opcode == OPC_JALR;

    assign br_taken_actual = is_jump || (is_branch && cond);
    assign flush  = is_jump || (is_branch && cond != br_taken);
    assign br_suc = is_branch && cond == br_taken;

    assign csr_en = inst.u.opcode == OPC_SYSTEM && inst.i.imm == CSR_TOHOST &&
                    (inst.i.funct3 == F3_CSRRW || inst.i.funct3 == F3_CSRRWI);
    assign csr_imm = inst.i.funct3 == F3_CSRRWI;

endmodule

//--- hdl/alu.sv
`timescale 1ns/1ps

module alu import rv_isa_pkg::*; (
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  alu_op_e     op,
    output logic [31:0] res
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:    res = a + b;
            ALU_SUB:    res = a - b;
            ALU_SLL:    res = a << shamt;
            ALU_SLT:    res = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU:   res = {31'b0, a < b};
            ALU_XOR:    res = a ^ b;
            ALU_SRL:    res = a >> shamt;
            ALU_SRA:    res = $unsigned($signed(a) >>> shamt);
            ALU_OR:     res = a | b;
            ALU_AND:    res = a & b;
            ALU_COPY_B: res = b; // LUI
            default:    res = '0;
        endcase
    end

endmodule

//--- hdl/pipe_pkg.sv
package pipe_pkg;

    import rv_isa_pkg::*;

    // Decoded instruction from the decode stage
    typedef struct packed {
        logic [31:0] pc;
        rv_inst_t    inst;
        logic [31:0] rd1;
        logic [31:0] rd2;
        logic [31:0] imm;
        logic        br_taken;
    } ex_in_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] alu;
        logic [31:0] rd2; // Store data, already forwarded
        rv_inst_t    inst;
        logic        br_suc;
    } mem_bundle_t;

    typedef struct packed {
        rv_inst_t    inst;
        logic [4:0]  rd;
        logic [31:0] wdata;
        logic        we;
    } wb_bundle_t;

    typedef enum logic [1:0] {FWD_NONE, FWD_MEM, FWD_WB} fwd_sel_e;

    typedef enum logic {A_REG, A_PC} a_sel_e;

    typedef enum logic {B_REG, B_IMM} b_sel_e;

endpackage

//--- hdl/rv_isa_pkg.sv
package rv_isa_pkg;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    // funct3 encodings for OP / OP_IMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // Branch conditions
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_CSRRW  = 3'b001;
    localparam logic [2:0] F3_CSRRWI = 3'b101;

    localparam logic [11:0] CSR_TOHOST = 12'h51E;
    localparam logic [31:0] NOP = 32'h0000_0013; // addi x0, x0, 0

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_COPY_B
    } alu_op_e;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            opcode_e    opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            opcode_e     opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            opcode_e    opcode;
        } s;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            opcode_e     opcode;
        } u;
    } rv_inst_t;

endpackage
